/* design/permutationPkg.sv */
package permutationPkg;

    // Truth table of a 4-variable function
    typedef logic [15:0] botWord_t;
    typedef logic [23:0] pcoeffSum_t;
    typedef logic [15:0] pcoeffCount_t;
    // Four 2-bit target indices, variable 0 in the low bits
    typedef logic [7:0] permCode_t;

    localparam int NUM_VARS = 4;
    localparam int PERMS_PER_HALF = 12;

    // All 24 permutations in lexicographic order of (p0, p1, p2, p3),
    // written as {p3, p2, p1, p0}
    localparam permCode_t PERM_TABLE [0:23] = '{
        8'b11_10_01_00, 8'b10_11_01_00, 8'b11_01_10_00, 8'b01_11_10_00,
        8'b10_01_11_00, 8'b01_10_11_00, 8'b11_10_00_01, 8'b10_11_00_01,
        8'b11_00_10_01, 8'b00_11_10_01, 8'b10_00_11_01, 8'b00_10_11_01,
        // Second half maps variable 0 to 2 or 3
        8'b11_01_00_10, 8'b01_11_00_10, 8'b11_00_01_10, 8'b00_11_01_10,
        8'b01_00_11_10, 8'b00_01_11_10, 8'b10_01_00_11, 8'b01_10_00_11,
        8'b10_00_01_11, 8'b00_10_01_11, 8'b01_00_10_11, 8'b00_01_10_11
    };

    // Bit j of the result is the input bit whose index has bit code[k]
    // equal to bit k of j
    function automatic botWord_t permuteBot(input botWord_t botIn, input permCode_t code);
        botWord_t permuted;
        logic [NUM_VARS-1:0] dstIndex;
        logic [NUM_VARS-1:0] srcIndex;
        permuted = '0;
        for (int j = 0; j < 2 ** NUM_VARS; j++) begin
            dstIndex = NUM_VARS'(j);
            srcIndex = '0;
            for (int k = 0; k < NUM_VARS; k++) begin
                srcIndex[code[2*k +: 2]] = dstIndex[k];
            end
            permuted[j] = botIn[srcIndex];
        end
        return permuted;
    endfunction

endpackage

/* design/botStream.sv */
`timescale 1ns/1ps

interface botStream import permutationPkg::*; ();

    botWord_t bot;
    logic botValid;
    // Set with the last bot of a batch
    logic batchDone;
    botWord_t top;

    modport source (
        output bot,
        output botValid,
        output batchDone,
        output top
    );

    modport sink (
        input bot,
        input botValid,
        input batchDone,
        input top
    );

endinterface

/* design/partialResult.sv */
`timescale 1ns/1ps

interface partialResult import permutationPkg::*; ();

    pcoeffSum_t sum;
    pcoeffCount_t count;
    // Held until grab is seen
    logic available;
    logic grab;

    modport producer (
        output sum,
        output count,
        output available,
        input grab
    );

    modport consumer (
        input sum,
        input count,
        input available,
        output grab
    );

endinterface

/* design/botInputStage.sv */
`timescale 1ns/1ps

module botInputStage import permutationPkg::*; (
    input logic clk,
    input logic rstN,
    input botWord_t topValue,
    input logic loadTop,
    input botWord_t bot,
    input logic writeBot,
    input logic batchEnd,
    input logic resultValid,
    output logic readyForInputBot,
    botStream.source stream
);

    logic accepted;
    // A finished batch whose result has not left yet
    logic resultPending;

    assign accepted = writeBot && !resultPending;
    assign readyForInputBot = !resultPending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stream.top <= '0;
        end else if (loadTop) begin
            stream.top <= topValue;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stream.botValid <= 1'b0;
            stream.batchDone <= 1'b0;
            resultPending <= 1'b0;
        end else begin
            stream.botValid <= accepted;
            stream.batchDone <= accepted && batchEnd;
            if (resultValid) begin
                resultPending <= 1'b0;
            end else if (accepted && batchEnd) begin
                resultPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            stream.bot <= bot;
        end
    end

endmodule

/* design/permuteAccumulator.sv */
`timescale 1ns/1ps

module permuteAccumulator import permutationPkg::*; #(
    parameter int HALF_INDEX = 0
) (
    input logic clk,
    input logic rstN,
    botStream.sink stream,
    partialResult.producer result
);

    botWord_t candidates [PERMS_PER_HALF];

    // Stage one
    botWord_t permutedBots [PERMS_PER_HALF];
    logic [PERMS_PER_HALF-1:0] hitFlags;
    botWord_t s1Top;
    logic s1Valid;
    logic s1Done;

    // Stage two
    pcoeffSum_t termSum;
    pcoeffCount_t hitCount;
    pcoeffSum_t s2Sum;
    pcoeffCount_t s2Count;
    logic s2Valid;
    logic s2Done;

    // This half's slice of the permutation table
    always_comb begin
        for (int i = 0; i < PERMS_PER_HALF; i++) begin
            candidates[i] = permuteBot(stream.bot, PERM_TABLE[HALF_INDEX * PERMS_PER_HALF + i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < PERMS_PER_HALF; i++) begin
            permutedBots[i] <= candidates[i];
            // Subset of top means no bit outside it
            hitFlags[i] <= (candidates[i] & ~stream.top) == '0;
        end
        s1Top <= stream.top;
    end

    // Uncovered top bits of every hit, plus the number of hits
    always_comb begin
        termSum = '0;
        hitCount = '0;
        for (int i = 0; i < PERMS_PER_HALF; i++) begin
            if (hitFlags[i]) begin
                termSum = termSum + pcoeffSum_t'($countones(s1Top & ~permutedBots[i]));
                hitCount = hitCount + pcoeffCount_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        s2Sum <= termSum;
        s2Count <= hitCount;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s1Done <= 1'b0;
            s2Valid <= 1'b0;
            s2Done <= 1'b0;
        end else begin
            s1Valid <= stream.botValid;
            s1Done <= stream.batchDone;
            s2Valid <= s1Valid;
            s2Done <= s1Done;
        end
    end

    // Batch accumulation is cleared once the combiner has taken the result
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result.sum <= '0;
            result.count <= '0;
            result.available <= 1'b0;
        end else if (result.grab) begin
            result.sum <= '0;
            result.count <= '0;
            result.available <= 1'b0;
        end else if (s2Valid) begin
            result.sum <= result.sum + s2Sum;
            result.count <= result.count + s2Count;
            if (s2Done) begin
                result.available <= 1'b1;
            end
        end
    end

endmodule

/* design/resultCombiner.sv */
`timescale 1ns/1ps

module resultCombiner import permutationPkg::*; (
    input logic clk,
    input logic rstN,
    partialResult.consumer lowHalf,
    partialResult.consumer highHalf,
    input logic slowDown,
    output logic resultValid,
    output pcoeffSum_t pcoeffSum,
    output pcoeffCount_t pcoeffCount
);

    logic bothAvailable;
    logic takeResult;
    logic grabPulse;

    assign bothAvailable = lowHalf.available && highHalf.available;

    // available is still high in the grab cycle, so skip that one
    assign takeResult = bothAvailable && !slowDown && !grabPulse;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            grabPulse <= 1'b0;
        end else begin
            grabPulse <= takeResult;
        end
    end

    // Outputs keep the last result between pulses
    always_ff @(posedge clk) begin
        if (takeResult) begin
            pcoeffSum <= lowHalf.sum + highHalf.sum;
            pcoeffCount <= lowHalf.count + highHalf.count;
        end
    end

    assign lowHalf.grab = grabPulse;
    assign highHalf.grab = grabPulse;
    // The grab and the result strobe share one edge
    assign resultValid = grabPulse;

endmodule

/* design/permutationCountTop.sv */
`timescale 1ns/1ps

module permutationCountTop import permutationPkg::*; (
    input logic clk,
    input logic rstN,
    input botWord_t topValue,
    input logic loadTop,
    input botWord_t bot,
    input logic writeBot,
    input logic batchEnd,
    output logic readyForInputBot,
    input logic slowDown,
    output logic resultValid,
    output pcoeffSum_t pcoeffSum,
    output pcoeffCount_t pcoeffCount
);

    botStream stream ();
    partialResult lowResult ();
    partialResult highResult ();

    botInputStage i_botInputStage (
        .clk(clk),
        .rstN(rstN),
        .topValue(topValue),
        .loadTop(loadTop),
        .bot(bot),
        .writeBot(writeBot),
        .batchEnd(batchEnd),
        .resultValid(resultValid),
        .readyForInputBot(readyForInputBot),
        .stream(stream.source)
    );

    // Permutations 0 to 11
    permuteAccumulator #(.HALF_INDEX(0)) i_lowAccumulator (
        .clk(clk),
        .rstN(rstN),
        .stream(stream.sink),
        .result(lowResult.producer)
    );

    // Permutations 12 to 23
    permuteAccumulator #(.HALF_INDEX(1)) i_highAccumulator (
        .clk(clk),
        .rstN(rstN),
        .stream(stream.sink),
        .result(highResult.producer)
    );

    resultCombiner i_resultCombiner (
        .clk(clk),
        .rstN(rstN),
        .lowHalf(lowResult.consumer),
        .highHalf(highResult.consumer),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

endmodule

/* bench/permutationRef.svh */
`ifndef PERMUTATION_REF_SVH
`define PERMUTATION_REF_SVH

function automatic int countBits(input botWord_t value);
    int ones;
    ones = 0;
    for (int i = 0; i < 16; i++) begin
        ones = ones + int'(value[i]);
    end
    return ones;
endfunction

// Bit j takes the source bit whose index carries bit k of j at position toK
function automatic botWord_t remapVars(input botWord_t value, input int to0, input int to1,
                                       input int to2, input int to3);
    botWord_t moved;
    int src;
    moved = '0;
    for (int j = 0; j < 16; j++) begin
        src = (((j >> 0) & 1) << to0) + (((j >> 1) & 1) << to1)
            + (((j >> 2) & 1) << to2) + (((j >> 3) & 1) << to3);
        moved[j] = value[src];
    end
    return moved;
endfunction

// Expected sum and hit count of a whole batch over all 24 variable orders
function automatic void expectBatch(input botWord_t topIn, input botWord_t bots [0:19],
                                    input int numBots, output pcoeffSum_t sumOut,
                                    output pcoeffCount_t countOut);
    botWord_t moved;
    sumOut = '0;
    countOut = '0;
    for (int n = 0; n < numBots; n++) begin
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 4; b++) begin
                for (int c = 0; c < 4; c++) begin
                    for (int d = 0; d < 4; d++) begin
                        if (a != b && a != c && a != d && b != c && b != d && c != d) begin
                            moved = remapVars(bots[n], a, b, c, d);
                            // A hit sets no bit outside top
                            if ((moved & ~topIn) == 16'h0000) begin
                                sumOut = sumOut + pcoeffSum_t'(countBits(topIn & ~moved));
                                countOut = countOut + 16'd1;
                            end
                        end
                    end
                end
            end
        end
    end
endfunction

`endif

/* bench/permutationCountTb.sv */
`timescale 1ns/1ps

module permutationCountTb import permutationPkg::*; ();

    `include "permutationRef.svh"

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MAX_WAIT = 200;
    localparam int RESULT_LATENCY = 5;

    logic clk;
    logic rstN;
    botWord_t topValue;
    logic loadTop;
    botWord_t bot;
    logic writeBot;
    logic batchEnd;
    logic readyForInputBot;
    logic slowDown;
    logic resultValid;
    pcoeffSum_t pcoeffSum;
    pcoeffCount_t pcoeffCount;

    int seed;
    int errorCount;
    int checkedCount;
    int cycleCount;
    botWord_t topShadow;
    botWord_t batchBots [0:19];
    int batchLen;
    pcoeffSum_t expSum [$];
    pcoeffCount_t expCount [$];
    string expName [$];

    permutationCountTop i_permutationCountTop (
        .clk(clk),
        .rstN(rstN),
        .topValue(topValue),
        .loadTop(loadTop),
        .bot(bot),
        .writeBot(writeBot),
        .batchEnd(batchEnd),
        .readyForInputBot(readyForInputBot),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped by timeout after %0d cycles", cycleCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int pickBelow(input int limit);
        return ($random(seed) & 32'h7fff_ffff) % limit;
    endfunction

    task automatic loadNewTop(input botWord_t value);
        @(negedge clk);
        topValue = value;
        loadTop = 1'b1;
        @(negedge clk);
        loadTop = 1'b0;
        topShadow = value;
    endtask

    // Partial bots may carry one bit outside top
    task automatic fillBatch(input int len, input bit partial);
        batchLen = len;
        for (int i = 0; i < len; i++) begin
            batchBots[i] = botWord_t'($random(seed)) & topShadow;
            if (partial && pickBelow(2) == 0) begin
                batchBots[i] = batchBots[i] | (16'h0001 << pickBelow(16));
            end
        end
    endtask

    task automatic runBatch(input string name, input bit stall);
        pcoeffSum_t sum;
        pcoeffCount_t count;
        int waited;
        int stretch;
        logic slowBeforeEdge;
        expectBatch(topShadow, batchBots, batchLen, sum, count);
        expSum.push_back(sum);
        expCount.push_back(count);
        expName.push_back(name);
        stretch = 1 + pickBelow(16);
        for (int i = 0; i < batchLen; i++) begin
            @(negedge clk);
            slowDown = stall;
            if (pickBelow(4) == 0) begin
                writeBot = 1'b0;
                batchEnd = 1'b0;
                @(negedge clk);
            end
            if (!readyForInputBot) begin
                $display("Input was refused in the middle of batch %s", name);
                errorCount++;
            end
            bot = batchBots[i];
            writeBot = 1'b1;
            batchEnd = (i == batchLen - 1);
        end
        @(negedge clk);
        writeBot = 1'b0;
        batchEnd = 1'b0;
        waited = 1;
        slowBeforeEdge = slowDown;
        while (!resultValid && waited < MAX_WAIT) begin
            if (readyForInputBot) begin
                $display("Error %s: readyForInputBot expected 0, actual 1", name);
                errorCount++;
            end
            if (stall) begin
                // Writes while input is refused must not reach the result
                writeBot = (pickBelow(2) == 1);
                batchEnd = (pickBelow(2) == 1);
                bot = botWord_t'($random(seed));
                stretch--;
                if (stretch == 0) begin
                    slowDown = !slowDown;
                    stretch = 1 + pickBelow(16);
                end
            end
            slowBeforeEdge = slowDown;
            @(negedge clk);
            waited++;
        end
        writeBot = 1'b0;
        batchEnd = 1'b0;
        slowDown = 1'b0;
        if (!resultValid) begin
            $display("Batch %s produced no result within %0d cycles", name, MAX_WAIT);
            errorCount++;
        end else begin
            if (slowBeforeEdge) begin
                $display("Batch %s was released while slowDown was high", name);
                errorCount++;
            end
            if (readyForInputBot) begin
                $display("Error %s: readyForInputBot expected 0, actual 1", name);
                errorCount++;
            end
            if (!stall && waited != RESULT_LATENCY) begin
                $display("Error %s: latency expected %0d, actual %0d",
                         name, RESULT_LATENCY, waited);
                errorCount++;
            end
        end
        @(negedge clk);
        if (!readyForInputBot) begin
            $display("Error %s: readyForInputBot expected 1, actual 0", name);
            errorCount++;
        end
        if (resultValid) begin
            $display("resultValid stayed high for more than one cycle after batch %s", name);
            errorCount++;
        end
    endtask

    always @(negedge clk) begin : compareResults
        string name;
        pcoeffSum_t wantSum;
        pcoeffCount_t wantCount;
        if (rstN && resultValid) begin
            if (expSum.size() == 0) begin
                $display("A result arrived with no batch outstanding");
                errorCount++;
            end else begin
                name = expName.pop_front();
                wantSum = expSum.pop_front();
                wantCount = expCount.pop_front();
                if (pcoeffSum !== wantSum) begin
                    $display("Error %s: sum expected %0d, actual %0d", name, wantSum, pcoeffSum);
                    errorCount++;
                end
                if (pcoeffCount !== wantCount) begin
                    $display("Error %s: count expected %0d, actual %0d",
                             name, wantCount, pcoeffCount);
                    errorCount++;
                end
                checkedCount++;
            end
        end
    end

    initial begin
        seed = 88;
        errorCount = 0;
        checkedCount = 0;
        rstN = 1'b0;
        topValue = '0;
        loadTop = 1'b0;
        bot = '0;
        writeBot = 1'b0;
        batchEnd = 1'b0;
        slowDown = 1'b0;
        topShadow = '0;
        batchLen = 0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        if (resultValid !== 1'b0) begin
            $display("Error afterReset: resultValid expected 0, actual %b", resultValid);
            errorCount++;
        end
        if (readyForInputBot !== 1'b1) begin
            $display("Error afterReset: readyForInputBot expected 1, actual %b", readyForInputBot);
            errorCount++;
        end
        // Every order hits a zero bot under a full top
        loadNewTop(16'hFFFF);
        batchLen = 1;
        batchBots[0] = 16'h0000;
        runBatch("allOnesTop", 1'b0);
        loadNewTop(16'h0000);
        batchBots[0] = 16'h8421;
        runBatch("zeroTop", 1'b0);
        for (int n = 0; n < 25; n++) begin
            loadNewTop(botWord_t'($random(seed)));
            fillBatch(1 + pickBelow(20), 1'b0);
            runBatch("randomBatch", 1'b0);
        end
        for (int n = 0; n < 20; n++) begin
            loadNewTop(botWord_t'($random(seed)));
            fillBatch(1 + pickBelow(20), 1'b0);
            runBatch("slowDownBatch", 1'b1);
        end
        for (int n = 0; n < 15; n++) begin
            loadNewTop(botWord_t'($random(seed)));
            fillBatch(1 + pickBelow(20), 1'b1);
            runBatch("topReloadBatch", 1'b0);
        end
        repeat (4) @(negedge clk);
        if (expSum.size() != 0) begin
            $display("%0d expected results never arrived", expSum.size());
            errorCount++;
        end
        $display("Checked %0d results, %0d errors", checkedCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* permutationCountTop.f */
+incdir+bench
design/permutationPkg.sv
design/botStream.sv
design/partialResult.sv
design/botInputStage.sv
design/permuteAccumulator.sv
design/resultCombiner.sv
design/permutationCountTop.sv
bench/permutationCountTb.sv
